// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat mips_cpu_bus.f)) design/mips_defs.svh

.PHONY: all run clean

all: obj_dir/Vmips_cpu_tb

obj_dir/Vmips_cpu_tb: mips_cpu_bus.f $(SRCS)
	verilator --binary --timing -f mips_cpu_bus.f --top-module mips_cpu_tb -o Vmips_cpu_tb

run: obj_dir/Vmips_cpu_tb
	./obj_dir/Vmips_cpu_tb | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== design/mips_alu.sv ====
`default_nettype none

module mips_alu (
    input  wire [31:0]       a,
    input  wire [31:0]       b,
    input  wire mips_pkg::alu_op_t op,
    output logic [31:0]      result,
    output logic             zero,
    output logic             negative
);

    logic a_lt_b; // signed compare for slt

    assign a_lt_b = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            mips_pkg::ALU_ADD: begin
                result = a + b; // addu, addiu, address calc
            end
            mips_pkg::ALU_SUB: begin
                result = a - b;
            end
            mips_pkg::ALU_AND: begin
                result = a & b;
            end
            mips_pkg::ALU_OR: begin
                result = a | b;
            end
            mips_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            mips_pkg::ALU_SLT: begin
                result = {31'd0, a_lt_b};
            end
            mips_pkg::ALU_PASS_B: begin
                result = b; // lui
            end
            default: begin
                result = a + b;
            end
        endcase
    end

    // branch condition flags, both taken from the operands
    assign zero     = (a == b); // beq / bne
    assign negative = a[31];    // bltz / bgez

endmodule

`default_nettype wire

// ==== design/mips_control.sv ====
`default_nettype none

`include "mips_defs.svh"

module mips_control (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         waitrequest,
    input  wire  [31:0] readdata,
    input  wire  [31:0] rs_data,
    input  wire  [31:0] rt_data,
    input  wire  [31:0] alu_result,
    input  wire         alu_zero,
    input  wire         alu_negative,
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    output logic [31:0] writedata,
    output logic [3:0]  byteenable,
    output logic        active,
    output logic [4:0]  rs_addr,
    output logic [4:0]  rt_addr,
    output logic        wr_en,
    output logic [4:0]  wr_addr,
    output logic [31:0] wr_data,
    output logic [31:0] alu_a,
    output logic [31:0] alu_b,
    output mips_pkg::alu_op_t alu_op
);

    mips_pkg::cpu_state_t state;

    logic [31:0] pc;
    logic [31:0] ir;
    logic [31:0] alu_out;        // result kept for wback / address
    logic [31:0] load_data;
    logic [31:0] branch_target;
    logic        branch_pending; // set by a taken branch in exec
    logic        in_delay;       // current instr is a delay slot

    mips_pkg::opcode_t opcode;
    mips_pkg::funct_t  funct;
    mips_pkg::regimm_t regimm;

    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic [31:0] imm_upper;
    logic [31:0] target;
    logic [31:0] next_pc;
    logic [31:0] mem_addr;
    logic [4:0]  dest;
    logic        writes_reg;
    logic        is_load;
    logic        is_store;
    logic        is_byte;
    logic        take_branch;

    assign opcode = mips_pkg::opcode_t'(ir[31:26]);
    assign funct  = mips_pkg::funct_t'(ir[5:0]);
    assign regimm = mips_pkg::regimm_t'(ir[20:16]);

    assign imm_sext  = {{16{ir[15]}}, ir[15:0]};
    assign imm_zext  = {16'h0000, ir[15:0]};
    assign imm_upper = {ir[15:0], 16'h0000};

    assign rs_addr  = ir[25:21];
    assign rt_addr  = ir[20:16];
    assign alu_a    = rs_data;
    assign active   = (state != mips_pkg::HALT);
    assign next_pc  = in_delay ? branch_target : pc + 32'd4;
    assign mem_addr = {alu_result[31:2], 2'b00}; // word aligned

    // write-back port
    assign wr_en   = (state == mips_pkg::WBACK) && writes_reg;
    assign wr_addr = dest;
    assign wr_data = is_load ? load_data : alu_out;

    // decode
    always_comb begin
        alu_op      = mips_pkg::ALU_ADD;
        alu_b       = rt_data;
        dest        = ir[20:16];
        writes_reg  = 1'b0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        is_byte     = 1'b0;
        take_branch = 1'b0;
        target      = pc + 32'd4 + {imm_sext[29:0], 2'b00}; // relative to slot
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                dest       = ir[15:11];
                writes_reg = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_JR: begin
                        writes_reg  = 1'b0;
                        take_branch = 1'b1;
                        target      = rs_data;
                    end
                    default: writes_reg = 1'b0;
                endcase
            end
            mips_pkg::OP_REGIMM: begin
                case (regimm)
                    mips_pkg::RI_BLTZ: take_branch = alu_negative;
                    mips_pkg::RI_BGEZ: take_branch = !alu_negative;
                    default:           take_branch = 1'b0;
                endcase
            end
            mips_pkg::OP_BEQ: take_branch = alu_zero;
            mips_pkg::OP_BNE: take_branch = !alu_zero;
            mips_pkg::OP_ADDIU: begin
                alu_b      = imm_sext;
                writes_reg = 1'b1;
            end
            mips_pkg::OP_ORI: begin
                alu_op     = mips_pkg::ALU_OR;
                alu_b      = imm_zext;
                writes_reg = 1'b1;
            end
            mips_pkg::OP_LUI: begin
                alu_op     = mips_pkg::ALU_PASS_B;
                alu_b      = imm_upper;
                writes_reg = 1'b1;
            end
            mips_pkg::OP_LW: begin
                alu_b      = imm_sext;
                is_load    = 1'b1;
                writes_reg = 1'b1;
            end
            mips_pkg::OP_SW: begin
                alu_b    = imm_sext;
                is_store = 1'b1;
            end
            mips_pkg::OP_SB: begin
                alu_b    = imm_sext;
                is_store = 1'b1;
                is_byte  = 1'b1;
            end
            default: writes_reg = 1'b0;
        endcase
    end

    // control state, strobes, pc and branch flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= mips_pkg::FETCH;
            pc             <= `MIPS_RESET_VECTOR;
            read           <= 1'b0;
            write          <= 1'b0;
            branch_pending <= 1'b0;
            in_delay       <= 1'b0;
        end else begin
            case (state)
                mips_pkg::FETCH: begin
                    if (!read) begin
                        read <= 1'b1; // first fetch after reset
                    end else if (!waitrequest) begin
                        read  <= 1'b0;
                        state <= mips_pkg::EXEC;
                    end
                end
                mips_pkg::EXEC: begin
                    branch_pending <= take_branch;
                    if (is_load || is_store) begin
                        read  <= is_load;
                        write <= is_store;
                        state <= mips_pkg::MEM;
                    end else begin
                        state <= mips_pkg::WBACK;
                    end
                end
                mips_pkg::MEM: begin
                    if (!waitrequest) begin
                        read  <= 1'b0;
                        write <= 1'b0;
                        state <= mips_pkg::WBACK;
                    end
                end
                mips_pkg::WBACK: begin
                    pc             <= next_pc;
                    in_delay       <= branch_pending;
                    branch_pending <= 1'b0;
                    if (in_delay && (branch_target == `MIPS_HALT_ADDR)) begin
                        state <= mips_pkg::HALT;
                    end else begin
                        read  <= 1'b1; // next fetch issued here
                        state <= mips_pkg::FETCH;
                    end
                end
                mips_pkg::HALT: state <= mips_pkg::HALT; // until reset
                default:        state <= mips_pkg::FETCH;
            endcase
        end
    end

    // payload registers, bus address and data
    always_ff @(posedge clk) begin
        case (state)
            mips_pkg::FETCH: begin
                if (!read) begin
                    address    <= pc;
                    byteenable <= 4'b1111;
                end else if (!waitrequest) begin
                    ir <= readdata;
                end
            end
            mips_pkg::EXEC: begin
                alu_out <= alu_result;
                if (take_branch) begin
                    branch_target <= target;
                end
                if (is_load || is_store) begin
                    address    <= mem_addr;
                    writedata  <= is_byte ? {4{rt_data[7:0]}} : rt_data; // sb repeats the byte
                    byteenable <= is_byte ? (4'b0001 << alu_result[1:0]) : 4'b1111;
                end
            end
            mips_pkg::MEM: begin
                if (!waitrequest) begin
                    load_data <= readdata;
                end
            end
            mips_pkg::WBACK: begin
                address    <= next_pc;
                byteenable <= 4'b1111;
            end
            default: begin
                address <= address;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/mips_cpu_bus.sv ====
`default_nettype none

module mips_cpu_bus (
    input  wire         clk,
    input  wire         rst_n,
    output logic        active,
    output logic [31:0] register_v0,

    // avalon master
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    input  wire         waitrequest,
    output logic [31:0] writedata,
    output logic [3:0]  byteenable,
    input  wire  [31:0] readdata
);

    logic [4:0]  rs_addr;
    logic [4:0]  rt_addr;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        wr_en;
    logic [4:0]  wr_addr;
    logic [31:0] wr_data;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic        alu_negative;

    mips_pkg::alu_op_t alu_op;

    mips_control control_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .waitrequest  (waitrequest),
        .readdata     (readdata),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .alu_result   (alu_result),
        .alu_zero     (alu_zero),
        .alu_negative (alu_negative),
        .address      (address),
        .read         (read),
        .write        (write),
        .writedata    (writedata),
        .byteenable   (byteenable),
        .active       (active),
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_op       (alu_op)
    );

    mips_regfile regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    mips_alu alu_i (
        .a        (alu_a),
        .b        (alu_b),
        .op       (alu_op),
        .result   (alu_result),
        .zero     (alu_zero),
        .negative (alu_negative)
    );

endmodule

`default_nettype wire

// ==== design/mips_defs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// address map of the core

// first instruction fetched after reset
`define MIPS_RESET_VECTOR 32'h0000_0004

// jump target that stops the core once its delay slot is done
`define MIPS_HALT_ADDR 32'h0000_0000

// register numbers

`define MIPS_REG_V0 5'd2 // result register, shown on register_v0

`endif

// ==== design/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, // r-type, see funct
        OP_REGIMM  = 6'h01, // bltz / bgez, see rt
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SB      = 6'h28,
        OP_SW      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef enum logic [4:0] {
        RI_BLTZ = 5'h00,
        RI_BGEZ = 5'h01
    } regimm_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B // lui, b already shifted
    } alu_op_t;

    typedef enum logic [2:0] {
        FETCH,
        EXEC,
        MEM,
        WBACK,
        HALT
    } cpu_state_t;

endpackage

`default_nettype wire

// ==== design/mips_regfile.sv ====
`default_nettype none

`include "mips_defs.svh"

module mips_regfile (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [4:0]  rs_addr,
    input  wire  [4:0]  rt_addr,
    input  wire         wr_en,
    input  wire  [4:0]  wr_addr,
    input  wire  [31:0] wr_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] v0
);

    logic [31:0] regs [31:1]; // r0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'h0000_0000;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data; // writes to r0 dropped
        end
    end

    // combinational read, r0 reads as zero
    always_comb begin
        rs_data = 32'h0000_0000;
        rt_data = 32'h0000_0000;
        if (rs_addr != 5'd0) begin
            rs_data = regs[rs_addr];
        end
        if (rt_addr != 5'd0) begin
            rt_data = regs[rt_addr];
        end
    end

    assign v0 = regs[`MIPS_REG_V0]; // tap for register_v0

endmodule

`default_nettype wire

// ==== mips_cpu_bus.f ====
+incdir+design
design/mips_pkg.sv
design/mips_regfile.sv
design/mips_alu.sv
design/mips_control.sv
design/mips_cpu_bus.sv
tests/tb_clock.sv
tests/avalon_ram_model.sv
tests/mips_checker.sv
tests/mips_cpu_tb.sv

// ==== tests/avalon_ram_model.sv ====
`default_nettype none

module avalon_ram_model (
    input  wire         clk,
    input  wire         stall_en,
    input  wire         load_en,
    input  wire  [7:0]  load_addr,
    input  wire  [31:0] load_data,
    input  wire  [31:0] address,
    input  wire         read,
    input  wire         write,
    input  wire  [31:0] writedata,
    input  wire  [3:0]  byteenable,
    output logic [31:0] readdata,
    output logic        waitrequest
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [0:255];           // 1 KB of words
    logic [15:0] lfsr = 16'd56487;
    logic        stall_q = 1'b0;

    function automatic logic [15:0] galois_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    assign waitrequest = stall_q;
    assign readdata    = read ? mem[address[9:2]] : 32'hxxxx_xxxx; // only driven for a read

    always @(posedge clk) begin
        logic [15:0] s1;
        logic [15:0] s2;
        s1 = galois_next(lfsr);
        s2 = galois_next(s1);
        lfsr <= s2;
        stall_q <= stall_en && lfsr[0] && s1[0]; // stall about one cycle in four
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (write && !waitrequest) begin
            for (int k = 0; k < 4; k++) begin
                if (byteenable[k]) begin
                    mem[address[9:2]][8*k +: 8] <= writedata[8*k +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/mips_checker.sv ====
`default_nettype none

`include "mips_defs.svh"

module mips_checker #(
    parameter int MAX_W = 64
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         active,
    input  wire  [31:0] register_v0,
    input  wire  [31:0] address,
    input  wire         read,
    input  wire         write,
    input  wire  [31:0] writedata,
    input  wire  [3:0]  byteenable,
    input  wire         waitrequest,
    input  int          test_id,
    input  int          exp_count,
    input  wire  [31:0] exp_v0,
    input  wire  [31:0] exp_waddr [0:MAX_W-1],
    input  wire  [31:0] exp_wdata [0:MAX_W-1],
    input  wire  [3:0]  exp_wbe [0:MAX_W-1],
    output int          errors
);

    timeunit 1ns;
    timeprecision 1ps;

    int   err_count = 0;
    int   widx = 0;              // next expected write
    logic first_pending = 1'b1;  // first transfer after reset not seen yet
    logic active_q = 1'b1;

    assign errors = err_count;

    always @(posedge clk) begin
        if (!rst_n) begin
            widx <= 0;
            first_pending <= 1'b1;
            active_q <= 1'b1;
            if (read || write) begin
                $display("run%0d: bus strobe high during reset", test_id);
                err_count = err_count + 1;
            end
        end else begin
            active_q <= active;
            if (read && write) begin
                $display("run%0d: read and write strobes high together", test_id);
                err_count = err_count + 1;
            end
            if (first_pending && (read || write)) begin
                first_pending <= 1'b0;
                if (!read || address != `MIPS_RESET_VECTOR) begin
                    $display("run%0d: first transfer is not a read at the reset vector",
                             test_id);
                    err_count = err_count + 1;
                end
            end
            if (write && !waitrequest) begin
                if (widx >= exp_count) begin
                    $display("run%0d: more bus writes than the model made", test_id);
                    err_count = err_count + 1;
                end else begin
                    if (address !== exp_waddr[widx]) begin
                        $display("Error run%0d write %0d address: expected %h, actual %h",
                                 test_id, widx, exp_waddr[widx], address);
                        err_count = err_count + 1;
                    end
                    if (writedata !== exp_wdata[widx]) begin
                        $display("Error run%0d write %0d data: expected %h, actual %h",
                                 test_id, widx, exp_wdata[widx], writedata);
                        err_count = err_count + 1;
                    end
                    if (byteenable !== exp_wbe[widx]) begin
                        $display("Error run%0d write %0d byteenable: expected %h, actual %h",
                                 test_id, widx, exp_wbe[widx], byteenable);
                        err_count = err_count + 1;
                    end
                end
                widx <= widx + 1;
            end
            if (active_q && !active) begin // halt reached
                if (register_v0 !== exp_v0) begin
                    $display("Error run%0d v0: expected %h, actual %h",
                             test_id, exp_v0, register_v0);
                    err_count = err_count + 1;
                end
                if (widx != exp_count) begin
                    $display("run%0d: halted after %0d writes, the model made %0d",
                             test_id, widx, exp_count);
                    err_count = err_count + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/mips_cpu_tb.sv ====
`default_nettype none

`include "mips_defs.svh"

module mips_cpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BODY    = 40; // random instructions before jr $0
    localparam int N_PROG  = 5;  // program 0 is the directed bltz case
    localparam int RUNS    = N_PROG * 2;
    localparam int MAX_W   = 64;
    localparam int TIMEOUT = RUNS * ((BODY + 3) * 12 + 256 + 40);

    logic        clk;
    logic        rst_n = 1'b0;
    logic        stall_en = 1'b0;
    logic        load_en = 1'b0;
    logic [7:0]  load_addr = 8'd0;
    logic [31:0] load_data = 32'd0;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;
    logic        waitrequest;

    logic [15:0] lfsr = 16'd56487;
    logic [31:0] img [0:255];
    logic [31:0] exp_waddr [0:MAX_W-1];
    logic [31:0] exp_wdata [0:MAX_W-1];
    logic [3:0]  exp_wbe [0:MAX_W-1];
    logic [31:0] exp_v0 = 32'd0;
    int          exp_count = 0;
    int          test_id = 0;
    int          checker_errors;
    int          tb_errors = 0;
    int          cycles = 0;

    tb_clock clock_i (.clk(clk));

    avalon_ram_model ram_i (
        .clk(clk), .stall_en(stall_en), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata),
        .waitrequest(waitrequest)
    );

    mips_cpu_bus dut_i (
        .clk(clk), .rst_n(rst_n), .active(active), .register_v0(register_v0),
        .address(address), .read(read), .write(write), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    mips_checker #(.MAX_W(MAX_W)) checker_i (
        .clk(clk), .rst_n(rst_n), .active(active), .register_v0(register_v0),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .waitrequest(waitrequest), .test_id(test_id),
        .exp_count(exp_count), .exp_v0(exp_v0), .exp_waddr(exp_waddr),
        .exp_wdata(exp_wdata), .exp_wbe(exp_wbe), .errors(checker_errors)
    );

    // msb first with one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h0101_0101) ^ 32'hC3A5_5A3C;
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [4:0] pick_reg(input logic dest);
        logic [31:0] v;
        v = take_bits(3);
        if (dest && v[2:0] == 3'd0) begin
            return 5'd7; // never write r0
        end
        return {2'b00, v[2:0]};
    endfunction

    // any instruction but a branch or jump
    function automatic logic [31:0] gen_plain();
        logic [31:0] kind;
        logic [31:0] v;
        logic [4:0]  d;
        logic [4:0]  s;
        logic [4:0]  t;
        logic [5:0]  fn;
        kind = take_bits(3);
        d = pick_reg(1'b1);
        s = pick_reg(1'b0);
        t = pick_reg(1'b0);
        v = take_bits(16);
        case (kind[2:0])
            3'd3: return enc_i(6'h09, s, d, v[15:0]);
            3'd4: return enc_i(6'h0d, s, d, v[15:0]);
            3'd5: return enc_i(6'h0f, 5'd0, d, v[15:0]);
            3'd6: return enc_i(6'h23, 5'd0, d, 16'h0200 + {10'd0, v[3:0], 2'b00});
            3'd7: begin
                if (v[15]) begin
                    return enc_i(6'h28, 5'd0, t, 16'h0200 + {10'd0, v[3:0], v[5:4]});
                end
                return enc_i(6'h2b, 5'd0, t, 16'h0200 + {10'd0, v[3:0], 2'b00});
            end
            default: begin
                case (v[2:0])
                    3'd1: fn = 6'h23;
                    3'd2: fn = 6'h24;
                    3'd3: fn = 6'h25;
                    3'd4: fn = 6'h26;
                    3'd5, 3'd7: fn = 6'h2a;
                    default: fn = 6'h21;
                endcase
                return {6'h00, s, t, d, 5'd0, fn};
            end
        endcase
    endfunction

    function automatic logic [31:0] gen_branch(input logic [15:0] off);
        logic [31:0] v;
        logic [4:0]  s;
        logic [4:0]  t;
        v = take_bits(2);
        s = pick_reg(1'b0);
        t = pick_reg(1'b0);
        case (v[1:0])
            2'd0: return enc_i(6'h04, s, t, off);
            2'd1: return enc_i(6'h05, s, t, off);
            2'd2: return enc_i(6'h01, s, 5'h00, off); // bltz
            default: return enc_i(6'h01, s, 5'h01, off); // bgez
        endcase
    endfunction

    task automatic build_program(input int t);
        int          p;
        logic [31:0] v;
        logic [15:0] off;
        for (int i = 0; i < 256; i++) begin
            img[i] = fill_word({22'd0, i[7:0], 2'b00});
        end
        if (t == 0) begin
            img[1] = enc_i(6'h09, 5'd0, 5'd2, 16'h0010);
            img[2] = enc_i(6'h0f, 5'd0, 5'd3, 16'h8000); // r3 negative
            img[3] = enc_i(6'h01, 5'd3, 5'h00, 16'd2);   // bltz to img[6]
            img[4] = enc_i(6'h09, 5'd2, 5'd2, 16'h0030); // delay slot
            img[5] = enc_i(6'h09, 5'd2, 5'd2, 16'h0001); // skipped
            img[6] = enc_i(6'h09, 5'd2, 5'd2, 16'h0030);
            img[7] = 32'h0000_0008;                      // jr $0
            img[8] = 32'h0000_0000;
        end else begin
            p = 0;
            while (p < BODY) begin
                v = take_bits(2);
                if (p + 1 < BODY && v[1:0] == 2'd0) begin
                    v = take_bits(2);
                    off = 16'd1 + {14'd0, v[1:0]};
                    if (int'(off) > BODY - p - 1) begin
                        off = 16'(BODY - p - 1); // land on jr $0 at the latest
                    end
                    img[1 + p] = gen_branch(off);
                    img[2 + p] = gen_plain();
                    p = p + 2;
                end else begin
                    img[1 + p] = gen_plain();
                    p = p + 1;
                end
            end
            img[1 + BODY] = 32'h0000_0008;
            img[2 + BODY] = 32'h0000_0000;
        end
    endtask

    task automatic record_write(input logic [31:0] a, input logic [31:0] d,
                                input logic [3:0] be);
        if (exp_count < MAX_W) begin
            exp_waddr[exp_count] = {a[31:2], 2'b00};
            exp_wdata[exp_count] = d;
            exp_wbe[exp_count]   = be;
        end
        exp_count = exp_count + 1;
    endtask

    // in-order ISA model with delay slots
    task automatic run_model();
        logic [31:0] regs [0:31];
        logic [31:0] mem [0:255];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] tgt;
        logic [31:0] slot_tgt;
        logic [3:0]  be;
        logic [4:0]  dst;
        logic        slot;
        logic        was_slot;
        logic        take;
        logic        wr;
        logic        running;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = img[i];
        end
        pc = `MIPS_RESET_VECTOR;
        slot = 1'b0;
        slot_tgt = 32'd0;
        exp_count = 0;
        running = 1'b1;
        steps = 0;
        while (running) begin
            ins  = mem[pc[9:2]];
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            sx   = {{16{ins[15]}}, ins[15:0]};
            addr = a + sx;
            tgt  = pc + 32'd4 + {sx[29:0], 2'b00};
            take = 1'b0;
            wr   = 1'b0;
            res  = 32'd0;
            dst  = ins[20:16];
            case (ins[31:26])
                6'h00: begin
                    dst = ins[15:11];
                    wr  = 1'b1;
                    case (ins[5:0])
                        6'h21: res = a + b;
                        6'h23: res = a - b;
                        6'h24: res = a & b;
                        6'h25: res = a | b;
                        6'h26: res = a ^ b;
                        6'h2a: res = {31'd0, $signed(a) < $signed(b)};
                        6'h08: begin
                            wr   = 1'b0;
                            take = 1'b1;
                            tgt  = a;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                6'h01: take = ins[16] ? !a[31] : a[31];
                6'h04: take = (a == b);
                6'h05: take = (a != b);
                6'h09: begin
                    res = a + sx;
                    wr  = 1'b1;
                end
                6'h0d: begin
                    res = a | {16'd0, ins[15:0]};
                    wr  = 1'b1;
                end
                6'h0f: begin
                    res = {ins[15:0], 16'd0};
                    wr  = 1'b1;
                end
                6'h23: begin
                    res = mem[addr[9:2]];
                    wr  = 1'b1;
                end
                6'h2b: begin
                    mem[addr[9:2]] = b;
                    record_write(addr, b, 4'b1111);
                end
                6'h28: begin
                    be = 4'b0001 << addr[1:0];
                    for (int k = 0; k < 4; k++) begin
                        if (be[k]) begin
                            mem[addr[9:2]][8*k +: 8] = b[7:0];
                        end
                    end
                    record_write(addr, {4{b[7:0]}}, be);
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
            end
            was_slot = slot;
            if (was_slot) begin
                if (slot_tgt == `MIPS_HALT_ADDR) begin
                    running = 1'b0;
                end
                pc = slot_tgt;
            end else begin
                pc = pc + 32'd4;
            end
            slot = take;
            if (take) begin
                slot_tgt = tgt;
            end
            steps = steps + 1;
            if (running && steps > 4 * BODY) begin
                $display("run%0d: reference model did not reach the halt", test_id);
                tb_errors = tb_errors + 1;
                running = 1'b0;
            end
        end
        exp_v0 = regs[2];
    endtask

    task automatic load_image();
        for (int i = 0; i < 256; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= i[7:0];
            load_data <= img[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: the core did not halt within %0d cycles", TIMEOUT);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        for (int t = 0; t < N_PROG; t++) begin
            build_program(t);
            for (int s = 0; s < 2; s++) begin
                test_id = t * 2 + s;
                run_model();
                load_image();
                @(posedge clk);
                rst_n    <= 1'b0;
                stall_en <= (s == 1);
                repeat (16) @(posedge clk);
                rst_n <= 1'b1;
                @(posedge clk);
                while (active) @(posedge clk);
                repeat (2) @(posedge clk); // let the checker see the halt
                if (t == 0 && register_v0 !== 32'h0000_0070) begin
                    $display("Error directed_bltz v0: expected %h, actual %h",
                             32'h0000_0070, register_v0);
                    tb_errors = tb_errors + 1;
                end
            end
        end
        $display("checker errors: %0d, testbench errors: %0d", checker_errors, tb_errors);
        if (checker_errors == 0 && tb_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial clk = 1'b0;

    always #4 clk = ~clk; // 8 ns period

endmodule

`default_nettype wire
